// ==== files.f ====
+incdir+.
pcs257_pkg.sv
tc_block_assembler.sv
tc_block_fifo.sv
tc_block_checker.sv
tc_check_top.sv
tb_tc_check_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
# The exit status of the simulation is the result of the run
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_tc_check_top \
    -f files.f \
    -o sim_tb_tc_check_top

./obj_dir/sim_tb_tc_check_top

// ==== tb_tc_check_top.sv ====
`include "pcs257_macros.svh"

module tb_tc_check_top;

    import pcs257_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    // Watchdog budget per table row
    localparam int ROW_CYCLES    = 50;
    // Longest wait for one row to drain
    localparam int WAIT_LIMIT    = 400;
    // Reset is applied again just before this row, once every counter has moved
    localparam int MID_RESET_ROW = 18;

    // Stimulus row with block kind, hold level, burst length and the idle gap after it
    typedef struct packed {
        logic         all_data;
        frame_kinds_t kinds;
        logic         corrupt;
        logic         hold;
        logic [7:0]   n_blocks;
        logic [7:0]   idle;
    } row_t;

    logic         clk;
    logic         i_rst;
    logic         i_blk_strobe;
    logic         i_all_data;
    frame_kinds_t i_frame_kinds;
    logic         i_corrupt;
    logic         i_hold;
    cnt_t         o_block_count;
    cnt_t         o_data_count;
    cnt_t         o_ctrl_count;
    cnt_t         o_inv_block_count;
    cnt_t         o_drop_count;
    logic         o_full;

    row_t   rows[$];
    logic   table_ready;
    integer seed;

    // Reference counters
    cnt_t exp_block;
    cnt_t exp_data;
    cnt_t exp_ctrl;
    cnt_t exp_inv;
    cnt_t exp_drop;

    tc_check_top i_tc_check_top (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_blk_strobe      (i_blk_strobe),
        .i_all_data        (i_all_data),
        .i_frame_kinds     (i_frame_kinds),
        .i_corrupt         (i_corrupt),
        .i_hold            (i_hold),
        .o_block_count     (o_block_count),
        .o_data_count      (o_data_count),
        .o_ctrl_count      (o_ctrl_count),
        .o_inv_block_count (o_inv_block_count),
        .o_drop_count      (o_drop_count),
        .o_full            (o_full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input cnt_t actual, input cnt_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at time %0t: %s is %0d, expected %0d",
                               $time, name, actual, expected));
        end
    endtask

    task automatic add_row(input logic all_data, input frame_kinds_t kinds, input logic corrupt,
                           input logic hold, input int n_blocks, input int idle);
        row_t r;
        r.all_data = all_data;
        r.kinds    = kinds;
        r.corrupt  = corrupt;
        r.hold     = hold;
        r.n_blocks = 8'(n_blocks);
        r.idle     = 8'(idle);
        rows.push_back(r);
    endtask

    task automatic load_table();
        // All-data blocks ignore the kind flags
        add_row(1'b1, 4'hF, 1'b0, 1'b0, 1, 2);
        add_row(1'b1, 4'h5, 1'b0, 1'b0, 3, 1);
        // One control frame at each position
        add_row(1'b0, 4'hE, 1'b0, 1'b0, 1, 1);
        add_row(1'b0, 4'hD, 1'b0, 1'b0, 1, 0);
        add_row(1'b0, 4'hB, 1'b0, 1'b0, 1, 2);
        add_row(1'b0, 4'h7, 1'b0, 1'b0, 1, 1);
        // Several control frames where only the first one is compressed
        add_row(1'b0, 4'hC, 1'b0, 1'b0, 1, 1);
        add_row(1'b0, 4'h3, 1'b0, 1'b0, 2, 0);
        add_row(1'b0, 4'h5, 1'b0, 1'b0, 1, 3);
        add_row(1'b0, 4'hA, 1'b0, 1'b0, 1, 1);
        add_row(1'b0, 4'h0, 1'b0, 1'b0, 2, 2);
        // Damaged pattern byte in frame 0
        add_row(1'b1, 4'hF, 1'b1, 1'b0, 1, 2);
        add_row(1'b0, 4'hE, 1'b1, 1'b0, 1, 1);
        add_row(1'b0, 4'h7, 1'b1, 1'b0, 1, 1);
        // Control header without any control frame
        add_row(1'b0, 4'hF, 1'b0, 1'b0, 1, 1);
        add_row(1'b0, 4'hF, 1'b1, 1'b0, 1, 2);
        // Bursts into a held checker with three blocks over the FIFO depth
        add_row(1'b1, 4'hF, 1'b0, 1'b1, `FIFO_DEPTH + 3, 2);
        add_row(1'b0, 4'h3, 1'b0, 1'b1, `FIFO_DEPTH + 3, 1);
        // Traffic resumes normally after the bursts
        add_row(1'b0, 4'h6, 1'b0, 1'b0, 4, 2);
        add_row(1'b0, 4'h9, 1'b1, 1'b0, 2, 1);
    endtask

    task automatic clear_model();
        exp_block = '0;
        exp_data  = '0;
        exp_ctrl  = '0;
        exp_inv   = '0;
        exp_drop  = '0;
    endtask

    // Expected effect of one block that reaches the checker
    task automatic model_block(input row_t r);
        exp_block = exp_block + 32'd1;
        if (r.all_data) begin
            exp_data = exp_data + 32'd1;
        end else begin
            exp_ctrl = exp_ctrl + 32'd1;
        end
        // A damaged byte or a control header with no control frame
        if (r.corrupt || (!r.all_data && r.kinds == 4'hF)) begin
            exp_inv = exp_inv + 32'd1;
        end
    endtask

    task automatic check_counters(input logic exp_full);
        check_value("o_block_count", o_block_count, exp_block);
        check_value("o_data_count", o_data_count, exp_data);
        check_value("o_ctrl_count", o_ctrl_count, exp_ctrl);
        check_value("o_inv_block_count", o_inv_block_count, exp_inv);
        check_value("o_drop_count", o_drop_count, exp_drop);
        check_value("o_full", cnt_t'(o_full), cnt_t'(exp_full));
    endtask

    task automatic apply_reset();
        @(negedge clk);
        i_rst        = 1'b1;
        i_blk_strobe = 1'b0;
        i_hold       = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        i_rst = 1'b0;
        clear_model();
    endtask

    // Wait until the checker has judged every expected block
    task automatic wait_for_blocks();
        int cycles;
        cycles = 0;
        while (o_block_count != exp_block) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_run($sformatf("Timeout: o_block_count stuck at %0d, waiting for %0d",
                                   o_block_count, exp_block));
            end
        end
    endtask

    task automatic run_row(input row_t r);
        int   n;
        int   n_kept;
        int   gap;
        cnt_t blocks_before;
        n             = int'(r.n_blocks);
        blocks_before = exp_block;
        // A held checker leaves room for FIFO_DEPTH blocks only
        n_kept = (r.hold && n > `FIFO_DEPTH) ? `FIFO_DEPTH : n;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            i_hold        = r.hold;
            i_blk_strobe  = 1'b1;
            i_all_data    = r.all_data;
            i_frame_kinds = r.kinds;
            i_corrupt     = r.corrupt;
            if (i < n_kept) begin
                model_block(r);
            end
        end
        @(negedge clk);
        i_blk_strobe = 1'b0;
        if (r.hold) begin
            exp_drop = exp_drop + cnt_t'(n - n_kept);
            // Let the last write reach the FIFO
            repeat (2) @(negedge clk);
            check_value("o_full", cnt_t'(o_full), cnt_t'(n >= `FIFO_DEPTH));
            check_value("o_drop_count", o_drop_count, exp_drop);
            check_value("o_block_count", o_block_count, blocks_before);
            i_hold = 1'b0;
        end
        wait_for_blocks();
        check_counters(1'b0);
        gap = int'(r.idle) + int'({$random(seed)} % 32'd4);
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        i_rst         = 1'b1;
        i_blk_strobe  = 1'b0;
        i_all_data    = 1'b0;
        i_frame_kinds = 4'h0;
        i_corrupt     = 1'b0;
        i_hold        = 1'b0;
        seed          = 32'h3874_3535;
        table_ready   = 1'b0;
        clear_model();
        load_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        i_rst = 1'b0;
        // Counters and levels straight out of reset
        check_counters(1'b0);
        for (int idx = 0; idx < rows.size(); idx++) begin
            if (idx == MID_RESET_ROW) begin
                apply_reset();
                check_counters(1'b0);
            end
            run_row(rows[idx]);
        end
        $display("test passed");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        int limit;
        wait (table_ready);
        limit = (rows.size() * ROW_CYCLES + 2 * RESET_CYCLES) * CLK_PERIOD;
        #(limit);
        fail_run("Watchdog expired: the stimulus table did not finish in time");
    end

endmodule

// ==== tc_check_top.sv ====
module tc_check_top (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_blk_strobe,
    input  logic                     i_all_data,
    input  pcs257_pkg::frame_kinds_t i_frame_kinds,
    input  logic                     i_corrupt,
    input  logic                     i_hold,
    output pcs257_pkg::cnt_t         o_block_count,
    output pcs257_pkg::cnt_t         o_data_count,
    output pcs257_pkg::cnt_t         o_ctrl_count,
    output pcs257_pkg::cnt_t         o_inv_block_count,
    output pcs257_pkg::cnt_t         o_drop_count,
    output logic                     o_full
);

    import pcs257_pkg::*;

    // Assembler to FIFO
    logic      wr_en;
    tc_block_t wr_block;

    // FIFO to checker
    logic      rd_en;
    logic      empty;
    tc_block_t rd_block;

    // Producer
    tc_block_assembler u_assembler (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_blk_strobe  (i_blk_strobe),
        .i_all_data    (i_all_data),
        .i_frame_kinds (i_frame_kinds),
        .i_corrupt     (i_corrupt),
        .o_wr_en       (wr_en),
        .o_wr_block    (wr_block)
    );

    // Block buffer, drops writes while full
    tc_block_fifo u_fifo (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_wr_en      (wr_en),
        .i_wr_block   (wr_block),
        .i_rd_en      (rd_en),
        .o_rd_block   (rd_block),
        .o_empty      (empty),
        .o_full       (o_full),
        .o_drop_count (o_drop_count)
    );

    // Consumer with statistics
    tc_block_checker u_checker (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_hold            (i_hold),
        .i_empty           (empty),
        .i_rd_block        (rd_block),
        .o_rd_en           (rd_en),
        .o_block_count     (o_block_count),
        .o_data_count      (o_data_count),
        .o_ctrl_count      (o_ctrl_count),
        .o_inv_block_count (o_inv_block_count)
    );

endmodule

// ==== tc_block_checker.sv ====
`include "pcs257_macros.svh"

module tc_block_checker (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_hold,
    input  logic                  i_empty,
    input  pcs257_pkg::tc_block_t i_rd_block,
    output logic                  o_rd_en,
    output pcs257_pkg::cnt_t      o_block_count,
    output pcs257_pkg::cnt_t      o_data_count,
    output pcs257_pkg::cnt_t      o_ctrl_count,
    output pcs257_pkg::cnt_t      o_inv_block_count
);

    import pcs257_pkg::*;

    chk_state_t state;
    chk_state_t state_next;

    // Kind flags of a control header
    frame_kinds_t kinds;

    // Expected pattern of the frame under test
    frame_t expect_frame;

    // Current bit position while walking the frames
    int offset;

    // Still looking for the compressed control frame
    logic first_ctrl;

    // Verdict on the block presented by the FIFO
    logic inv_flag;

    // Verdict sampled in fetch, applied in judge
    logic is_data_q;
    logic inv_q;

    // Pull one block when something is waiting and no hold
    assign o_rd_en = (state == st_idle) && !i_empty && !i_hold;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (o_rd_en) begin
                    state_next = st_fetch;
                end
            end
            st_fetch: state_next = st_judge;
            st_judge: state_next = st_idle;
            default:  state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Block classification
    always_comb begin
        kinds        = i_rd_block[4:1];
        inv_flag     = 1'b0;
        first_ctrl   = 1'b1;
        expect_frame = '0;
        offset       = 1;

        if (i_rd_block[0]) begin
            // All data, four plain frames after the header
            for (int i = 0; i < $bits(frame_kinds_t); i++) begin
                if (i_rd_block[1 + `FRAME_W*i +: `FRAME_W] != `DATA_FRAME) begin
                    inv_flag = 1'b1;
                end
            end
        end else if (&kinds) begin
            // Control header without a single control frame
            inv_flag = 1'b1;
        end else begin
            // Frames start after the four kind flags
            offset = 5;
            for (int i = 0; i < $bits(frame_kinds_t); i++) begin
                expect_frame = kinds[i] ? `DATA_FRAME : `CTRL_FRAME;
                if (!kinds[i] && first_ctrl) begin
                    // Compressed frame, 60 bits only
                    if (i_rd_block[offset +: `FRAME_W-`CTRL_DROP_W] !=
                        expect_frame[`FRAME_W-`CTRL_DROP_W-1:0]) begin
                        inv_flag = 1'b1;
                    end
                    offset     = offset + `FRAME_W - `CTRL_DROP_W;
                    first_ctrl = 1'b0;
                end else begin
                    if (i_rd_block[offset +: `FRAME_W] != expect_frame) begin
                        inv_flag = 1'b1;
                    end
                    offset = offset + `FRAME_W;
                end
            end
        end
    end

    // FIFO data is valid in fetch
    always_ff @(posedge clk) begin
        if (state == st_fetch) begin
            is_data_q <= i_rd_block[0];
            inv_q     <= inv_flag;
        end
    end

    // Statistics, one update per block in judge
    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_block_count     <= '0;
            o_data_count      <= '0;
            o_ctrl_count      <= '0;
            o_inv_block_count <= '0;
        end else if (state == st_judge) begin
            o_block_count <= o_block_count + 1'b1;
            if (is_data_q) begin
                o_data_count <= o_data_count + 1'b1;
            end else begin
                o_ctrl_count <= o_ctrl_count + 1'b1;
            end
            if (inv_q) begin
                o_inv_block_count <= o_inv_block_count + 1'b1;
            end
        end
    end

endmodule

// ==== tc_block_fifo.sv ====
`include "pcs257_macros.svh"

module tc_block_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_wr_en,
    input  pcs257_pkg::tc_block_t i_wr_block,
    input  logic                  i_rd_en,
    output pcs257_pkg::tc_block_t o_rd_block,
    output logic                  o_empty,
    output logic                  o_full,
    output pcs257_pkg::cnt_t      o_drop_count
);

    import pcs257_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // Block storage
    tc_block_t mem [DEPTH];

    // Pointers with an extra wrap bit on top
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_write;
    logic do_read;

    // Same index, same lap means empty
    assign o_empty = (wr_ptr == rd_ptr);

    // Same index, different lap means full
    assign o_full = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Writes while full are discarded
    assign do_write = i_wr_en && !o_full;
    assign do_read  = i_rd_en && !o_empty;

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            o_drop_count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Count every block lost to a full buffer
            if (i_wr_en && o_full) begin
                o_drop_count <= o_drop_count + 1'b1;
            end
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= i_wr_block;
        end
    end

    // Registered head block, valid the cycle after the read
    always_ff @(posedge clk) begin
        if (do_read) begin
            o_rd_block <= mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

// ==== tc_block_assembler.sv ====
`include "pcs257_macros.svh"

module tc_block_assembler (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_blk_strobe,
    input  logic                     i_all_data,
    input  pcs257_pkg::frame_kinds_t i_frame_kinds,
    input  logic                     i_corrupt,
    output logic                     o_wr_en,
    output pcs257_pkg::tc_block_t    o_wr_block
);

    import pcs257_pkg::*;

    // Effective kind of each frame, all data when the header is 1
    frame_kinds_t frame_kinds;

    // Pattern of the frame being placed
    frame_t frame;

    // Four spare bits on top so that an all-flags-set control header
    // can still be laid out before truncation
    logic [`TC_W+3:0] blk_wide;

    // Next free bit position in the block
    int offset;

    // Still looking for the first control frame
    logic first_ctrl;

    tc_block_t blk_next;

    always_comb begin
        frame_kinds = i_all_data ? 4'hF : i_frame_kinds;
        blk_wide    = '0;
        first_ctrl  = 1'b1;
        frame       = '0;

        // Header bit
        blk_wide[0] = i_all_data;

        // Control header carries the kind flags in bits 1..4
        if (i_all_data) begin
            offset = 1;
        end else begin
            blk_wide[4:1] = i_frame_kinds;
            offset        = 5;
        end

        for (int i = 0; i < $bits(frame_kinds_t); i++) begin
            frame = frame_kinds[i] ? `DATA_FRAME : `CTRL_FRAME;

            // Damage the low byte of frame 0 on request
            if (i == 0 && i_corrupt) begin
                frame[7:0] = ~frame[7:0];
            end

            if (!frame_kinds[i] && first_ctrl) begin
                // First control frame loses its top bits,
                // later frames move down to close the gap
                blk_wide[offset +: `FRAME_W-`CTRL_DROP_W] =
                    frame[`FRAME_W-`CTRL_DROP_W-1:0];
                offset     = offset + `FRAME_W - `CTRL_DROP_W;
                first_ctrl = 1'b0;
            end else begin
                blk_wide[offset +: `FRAME_W] = frame;
                offset = offset + `FRAME_W;
            end
        end

        // Only the all-flags-set case spills above bit 256
        blk_next = blk_wide[`TC_W-1:0];
    end

    // Write strobe, one cycle after the request
    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_blk_strobe;
        end
    end

    // Block payload, valid together with the write strobe
    always_ff @(posedge clk) begin
        if (i_blk_strobe) begin
            o_wr_block <= blk_next;
        end
    end

endmodule

// ==== pcs257_pkg.sv ====
`include "pcs257_macros.svh"

package pcs257_pkg;

    // Full 257b transcoded block, bit 0 is the header
    typedef logic [`TC_W-1:0] tc_block_t;

    // One 64b frame
    typedef logic [`FRAME_W-1:0] frame_t;

    // Per-frame kind flags, 1 means data
    typedef logic [3:0] frame_kinds_t;

    // Statistics counter
    typedef logic [`CNT_W-1:0] cnt_t;

    // Checker FSM
    // Idle waits for a block, fetch waits for FIFO read data,
    // judge applies the verdict to the counters
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_fetch = 2'd1,
        st_judge = 2'd2
    } chk_state_t;

endpackage

// ==== pcs257_macros.svh ====
`ifndef PCS257_MACROS_SVH
`define PCS257_MACROS_SVH

// Width of one 64b frame
`define FRAME_W 64

// Transcoded block: 1 header bit plus four frames
`define TC_W 257

// Data character, one byte per lane
`define DATA_CHAR 8'hAA

// Control character, seven bits per lane
`define CTRL_CHAR 7'h1E

// Blocks held by the buffer, power of two
`define FIFO_DEPTH 8

// Width of every statistics counter
`define CNT_W 32

// Expected frame contents
`define DATA_FRAME {8{`DATA_CHAR}}
`define CTRL_FRAME {8'h00, {8{`CTRL_CHAR}}}

// Bits dropped from the first control frame
`define CTRL_DROP_W 4

`endif
